/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_issue_decoder
RTL_TOP   ?= issue_decoder_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sources.f */
+incdir+src
+incdir+testbench
src/decode_pkg.sv
src/inst_field_decoder.sv
src/operand_resolver.sv
src/dispatch_unit.sv
src/issue_decoder_top.sv
testbench/tb_issue_decoder.sv

/* src/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// width of one data word and of every address in the core
`define XLEN 32

// architectural register number, x0 to x31
`define REG_IDX_W 5

// number of entries in the reorder buffer and in the load/store buffer
`define ROB_DEPTH 16
`define LSB_DEPTH 16

// a ROB tag names one of the ROB_DEPTH entries
`define ROB_TAG_W 4

// rs1 and rs2 are looked up and resolved side by side
`define NUM_SRC 2

// the JALR target always has its lowest bit cleared
`define JALR_ALIGN_MASK {{(`XLEN - 1){1'b1}}, 1'b0}

`endif

/* src/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // one extra bit so that a full counter can hold the depth itself
    typedef logic [$clog2(`ROB_DEPTH + 1)-1:0] credit_t;

    // upper-immediate covers both LUI and AUIPC
    typedef enum logic [3:0] {
        CLS_UPPER,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_ILLEGAL
    } inst_class_e;

    // encodings are fixed because the ROB decodes them directly
    typedef enum logic [1:0] {
        REG_WRITE = 2'b00,
        STORE     = 2'b01,
        BRANCH    = 2'b10
    } rob_type_e;

    typedef enum logic {
        IDLE,
        WAIT_TARGET
    } jalr_state_e;

    // register file answer for one source, with the ROB entry already looked up
    typedef struct packed {
        logic     dirty;
        word_t    rf_value;
        rob_tag_t rob_tag;
        logic     rob_ready;
        word_t    rob_value;
    } src_lookup_t;

    // result broadcast from an execution unit
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    // a resolved operand, or the tag it still waits for
    typedef struct packed {
        word_t    value;
        logic     need_rob;
        rob_tag_t rob_tag;
    } operand_t;

    typedef struct packed {
        inst_class_e inst_class;
        logic [2:0]  funct3;
        logic        funct7_b30;
        reg_idx_t    rd;
        word_t       imm;
        rob_type_e   rob_type;
        logic        rob_ready;
        word_t       rob_ans;
        logic        to_rs;
        logic        to_lsb;
        logic        is_store;
        logic        writes_rd;
        word_t       pc;
        logic        pred_jump;
        word_t       jalr_offset;
    } decoded_t;

    typedef struct packed {
        decoded_t                   dec;
        operand_t [`NUM_SRC-1:0]    src;
        rob_tag_t                   rob_tag;
    } dispatch_t;

endpackage

/* src/dispatch_unit.sv */
`timescale 1ns/1ps
`include "decode_params.svh"

module dispatch_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rollback,
    input  logic                                inst_valid,
    input  decode_pkg::decoded_t                decoded,
    input  decode_pkg::operand_t [`NUM_SRC-1:0] operands,
    input  decode_pkg::cdb_t                    alu_cdb,
    input  decode_pkg::cdb_t                    lsb_cdb,
    input  decode_pkg::rob_tag_t                alloc_tag,
    input  logic                                rob_credit_return,
    input  logic                                lsb_credit_return,
    output logic                                inst_ready,
    output logic                                dispatch_valid,
    output decode_pkg::dispatch_t               dispatch,
    output logic                                redirect_valid,
    output decode_pkg::word_t                   redirect_pc,
    output logic                                jalr_stall
);
    import decode_pkg::*;

    localparam credit_t ROB_FULL = credit_t'(`ROB_DEPTH);
    localparam credit_t LSB_FULL = credit_t'(`LSB_DEPTH);

    credit_t     rob_credit;
    credit_t     lsb_credit;
    jalr_state_e state;
    rob_tag_t    wait_tag;
    word_t       saved_offset;
    logic        accept;
    logic        is_jalr;
    logic        alu_hit;
    logic        lsb_hit;
    logic        wake;
    word_t       jalr_base;
    word_t       jalr_off;
    word_t       jalr_target;

    // a return and a spend in the same cycle leave the count unchanged
    function automatic credit_t credit_next(credit_t cnt, logic ret, logic spend);
        credit_t nxt;
        nxt = cnt;
        if (ret && !spend) begin
            nxt = cnt + 1'b1;
        end else if (!ret && spend) begin
            nxt = cnt - 1'b1;
        end
        return nxt;
    endfunction

    // every instruction needs a free LSB slot too, not only loads and stores
    assign inst_ready = (state == IDLE) && (rob_credit != '0) && (lsb_credit != '0);
    assign accept     = inst_valid && inst_ready;
    assign is_jalr    = (decoded.inst_class == CLS_JALR);
    assign jalr_stall = (state == WAIT_TARGET);

    // while waiting, watch both broadcasts for the tag that produces rs1
    assign alu_hit = alu_cdb.valid && (alu_cdb.tag == wait_tag);
    assign lsb_hit = lsb_cdb.valid && (lsb_cdb.tag == wait_tag);
    assign wake    = (state == WAIT_TARGET) && (alu_hit || lsb_hit);

    // one adder serves both the immediate target and the delayed one
    always_comb begin
        if (state == WAIT_TARGET) begin
            jalr_base = alu_hit ? alu_cdb.value : lsb_cdb.value;
            jalr_off  = saved_offset;
        end else begin
            jalr_base = operands[0].value;
            jalr_off  = decoded.jalr_offset;
        end
        jalr_target = (jalr_base + jalr_off) & `JALR_ALIGN_MASK;
    end

    // a flush empties the back end, so both buffers are free again
    always_ff @(posedge clk) begin
        if (reset || rollback) begin
            rob_credit <= ROB_FULL;
            lsb_credit <= LSB_FULL;
        end else begin
            rob_credit <= credit_next(rob_credit, rob_credit_return, accept);
            lsb_credit <= credit_next(lsb_credit, lsb_credit_return,
                                      accept && decoded.to_lsb);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || rollback) begin
            state          <= IDLE;
            dispatch_valid <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            dispatch_valid <= accept;
            redirect_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept && is_jalr) begin
                        // an unresolved base holds fetch until its producer broadcasts
                        if (operands[0].need_rob) begin
                            state <= WAIT_TARGET;
                        end else begin
                            redirect_valid <= 1'b1;
                        end
                    end
                end
                WAIT_TARGET: begin
                    if (wake) begin
                        state          <= IDLE;
                        redirect_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload registers, only qualified by the valid flags above
    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch.dec     <= decoded;
            dispatch.src     <= operands;
            dispatch.rob_tag <= alloc_tag;
        end
        if (accept && is_jalr) begin
            wait_tag     <= operands[0].rob_tag;
            saved_offset <= decoded.jalr_offset;
        end
        if ((accept && is_jalr) || wake) begin
            redirect_pc <= jalr_target;
        end
    end

endmodule

/* src/inst_field_decoder.sv */
`timescale 1ns/1ps
`include "decode_params.svh"

module inst_field_decoder (
    input  decode_pkg::word_t                   inst,
    input  decode_pkg::word_t                   inst_pc,
    input  logic                                pred_jump,
    output decode_pkg::decoded_t                decoded,
    output decode_pkg::reg_idx_t [`NUM_SRC-1:0] rs_index
);
    import decode_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // register indices go to the register file whatever the class
    assign rs_index[0] = inst[19:15];
    assign rs_index[1] = inst[24:20];

    // every immediate format is built in parallel and the class picks one
    assign imm_i = {{21{inst[31]}}, inst[30:20]};
    assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        decoded             = '0;
        decoded.funct3      = inst[14:12];
        decoded.funct7_b30  = inst[30];
        decoded.rd          = inst[11:7];
        decoded.pc          = inst_pc;
        decoded.pred_jump   = pred_jump;
        decoded.jalr_offset = imm_i;
        decoded.rob_type    = REG_WRITE;
        decoded.inst_class  = CLS_ILLEGAL;

        case (inst[6:0])
            7'b0110111, 7'b0010111: begin
                decoded.inst_class = CLS_UPPER;
                decoded.imm        = imm_u;
                decoded.writes_rd  = 1'b1;
                // LUI needs no unit at all, AUIPC still adds the pc in the ALU
                if (inst[5]) begin
                    decoded.rob_ready = 1'b1;
                    decoded.rob_ans   = imm_u;
                end else begin
                    decoded.to_rs = 1'b1;
                end
            end
            7'b1101111: begin
                decoded.inst_class = CLS_JAL;
                decoded.imm        = imm_j;
                decoded.to_rs      = 1'b1;
                decoded.writes_rd  = 1'b1;
            end
            7'b1100111: begin
                // the link value is known now, the target is handled by dispatch
                decoded.inst_class = CLS_JALR;
                decoded.imm        = imm_i;
                decoded.writes_rd  = 1'b1;
                decoded.rob_ready  = 1'b1;
                decoded.rob_ans    = inst_pc + 32'd4;
            end
            7'b1100011: begin
                decoded.inst_class = CLS_BRANCH;
                decoded.imm        = imm_b;
                decoded.rd         = '0;
                decoded.rob_type   = BRANCH;
                decoded.to_rs      = 1'b1;
            end
            7'b0000011: begin
                decoded.inst_class = CLS_LOAD;
                decoded.imm        = imm_i;
                decoded.to_lsb     = 1'b1;
                decoded.writes_rd  = 1'b1;
            end
            7'b0100011: begin
                // a store commits from the LSB, so its ROB entry is ready at once
                decoded.inst_class = CLS_STORE;
                decoded.imm        = imm_s;
                decoded.rd         = '0;
                decoded.rob_type   = STORE;
                decoded.rob_ready  = 1'b1;
                decoded.to_lsb     = 1'b1;
                decoded.is_store   = 1'b1;
            end
            7'b0010011: begin
                decoded.inst_class = CLS_OP_IMM;
                decoded.imm        = imm_i;
                decoded.to_rs      = 1'b1;
                decoded.writes_rd  = 1'b1;
            end
            7'b0110011: begin
                decoded.inst_class = CLS_OP;
                decoded.to_rs      = 1'b1;
                decoded.writes_rd  = 1'b1;
            end
            default: begin
                // unknown opcodes are passed on with no routing and no rd write
                decoded.inst_class = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

/* src/issue_decoder_top.sv */
`timescale 1ns/1ps
`include "decode_params.svh"

module issue_decoder_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   rollback,
    input  logic                                   inst_valid,
    input  decode_pkg::word_t                      inst,
    input  decode_pkg::word_t                      inst_pc,
    input  logic                                   pred_jump,
    output logic                                   inst_ready,
    output decode_pkg::reg_idx_t [`NUM_SRC-1:0]    rs_index,
    input  decode_pkg::src_lookup_t [`NUM_SRC-1:0] src_lookup,
    input  decode_pkg::cdb_t                       alu_cdb,
    input  decode_pkg::cdb_t                       lsb_cdb,
    input  decode_pkg::rob_tag_t                   alloc_tag,
    input  logic                                   rob_credit_return,
    input  logic                                   lsb_credit_return,
    output logic                                   dispatch_valid,
    output decode_pkg::dispatch_t                  dispatch,
    output logic                                   redirect_valid,
    output decode_pkg::word_t                      redirect_pc,
    output logic                                   jalr_stall
);
    import decode_pkg::*;

    decoded_t                decoded;
    operand_t [`NUM_SRC-1:0] operands;

    // the register file answers rs_index in the same cycle through src_lookup
    inst_field_decoder i_field_decoder (
        .inst      (inst),
        .inst_pc   (inst_pc),
        .pred_jump (pred_jump),
        .decoded   (decoded),
        .rs_index  (rs_index)
    );

    // rs1 and rs2 are resolved by identical units
    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_resolver
        operand_resolver i_resolver (
            .lookup  (src_lookup[i]),
            .alu_cdb (alu_cdb),
            .lsb_cdb (lsb_cdb),
            .operand (operands[i])
        );
    end

    dispatch_unit i_dispatch (
        .clk               (clk),
        .reset             (reset),
        .rollback          (rollback),
        .inst_valid        (inst_valid),
        .decoded           (decoded),
        .operands          (operands),
        .alu_cdb           (alu_cdb),
        .lsb_cdb           (lsb_cdb),
        .alloc_tag         (alloc_tag),
        .rob_credit_return (rob_credit_return),
        .lsb_credit_return (lsb_credit_return),
        .inst_ready        (inst_ready),
        .dispatch_valid    (dispatch_valid),
        .dispatch          (dispatch),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc),
        .jalr_stall        (jalr_stall)
    );

endmodule

/* src/operand_resolver.sv */
`timescale 1ns/1ps

module operand_resolver (
    input  decode_pkg::src_lookup_t lookup,
    input  decode_pkg::cdb_t        alu_cdb,
    input  decode_pkg::cdb_t        lsb_cdb,
    output decode_pkg::operand_t    operand
);

    logic alu_hit;
    logic lsb_hit;

    // a broadcast only counts when it carries the tag this source waits for
    assign alu_hit = alu_cdb.valid && (alu_cdb.tag == lookup.rob_tag);
    assign lsb_hit = lsb_cdb.valid && (lsb_cdb.tag == lookup.rob_tag);

    always_comb begin
        operand = '0;
        if (!lookup.dirty) begin
            // no pending writer, the architectural value is current
            operand.value = lookup.rf_value;
        end else if (lookup.rob_ready) begin
            // the writer has finished but not yet committed
            operand.value = lookup.rob_value;
        end else if (alu_hit) begin
            operand.value = alu_cdb.value;
        end else if (lsb_hit) begin
            operand.value = lsb_cdb.value;
        end else begin
            // still in flight, the reservation station snoops for this tag
            operand.need_rob = 1'b1;
            operand.rob_tag  = lookup.rob_tag;
        end
    end

endmodule

/* testbench/tb_decoder_model.svh */
`ifndef TB_DECODER_MODEL_SVH
`define TB_DECODER_MODEL_SVH

// RV32I major opcodes, one per class except upper-immediate, which has two
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;

logic [31:0] rng_state = 32'h6ba;

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// class numbers follow the order of the class enum, illegal excluded
function automatic word_t gen_inst(input int cls);
    word_t w;
    logic [6:0] opc;
    w = xorshift();
    case (cls)
        0: opc = w[12] ? OPC_LUI : OPC_AUIPC;
        1: opc = OPC_JAL;
        2: opc = OPC_JALR;
        3: opc = OPC_BRANCH;
        4: opc = OPC_LOAD;
        5: opc = OPC_STORE;
        6: opc = OPC_OP_IMM;
        default: opc = OPC_OP;
    endcase
    return {w[31:7], opc};
endfunction

// a lookup that is dirty half the time, with a ready ROB entry a quarter of the time
function automatic src_lookup_t rand_lookup();
    src_lookup_t l;
    logic [31:0] r;
    r = xorshift();
    l.dirty     = r[0];
    l.rob_ready = r[1] & r[2];
    l.rob_tag   = r[7:4];
    l.rf_value  = xorshift();
    l.rob_value = xorshift();
    return l;
endfunction

// broadcast tags hit one of the two sources more often than chance would
function automatic cdb_t rand_cdb(input rob_tag_t t0, input rob_tag_t t1);
    cdb_t c;
    logic [31:0] r;
    r = xorshift();
    c.valid = r[0];
    case (r[2:1])
        2'd0: c.tag = t0;
        2'd1: c.tag = t1;
        default: c.tag = r[11:8];
    endcase
    c.value = xorshift();
    return c;
endfunction

// priority is register file, finished ROB entry, ALU broadcast, LSB broadcast
function automatic operand_t ref_operand(input src_lookup_t l, input cdb_t alu,
                                         input cdb_t lsb);
    operand_t o;
    o = '0;
    if (l.dirty == 1'b0) begin
        o.value = l.rf_value;
    end else if (l.rob_ready) begin
        o.value = l.rob_value;
    end else if (alu.valid && alu.tag == l.rob_tag) begin
        o.value = alu.value;
    end else if (lsb.valid && lsb.tag == l.rob_tag) begin
        o.value = lsb.value;
    end else begin
        o.need_rob = 1'b1;
        o.rob_tag  = l.rob_tag;
    end
    return o;
endfunction

function automatic word_t jalr_target(input word_t base, input word_t offset);
    word_t sum;
    sum = base + offset;
    return {sum[31:1], 1'b0};
endfunction

// decode straight from the ISA encoding tables
function automatic decoded_t ref_decode(input word_t w, input word_t pc, input logic pj);
    decoded_t d;
    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;
    i_imm = {{20{w[31]}}, w[31:20]};
    s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
    b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    u_imm = {w[31:12], 12'h000};
    j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    d = '0;
    d.inst_class  = CLS_ILLEGAL;
    d.funct3      = w[14:12];
    d.funct7_b30  = w[30];
    d.rd          = w[11:7];
    d.pc          = pc;
    d.pred_jump   = pj;
    d.jalr_offset = i_imm;
    d.rob_type    = REG_WRITE;
    case (w[6:0])
        OPC_LUI: begin
            d.inst_class = CLS_UPPER;
            d.imm = u_imm;
            d.writes_rd = 1'b1;
            d.rob_ready = 1'b1;
            d.rob_ans = u_imm;
        end
        OPC_AUIPC: begin
            d.inst_class = CLS_UPPER;
            d.imm = u_imm;
            d.writes_rd = 1'b1;
            d.to_rs = 1'b1;
        end
        OPC_JAL: begin
            d.inst_class = CLS_JAL;
            d.imm = j_imm;
            d.writes_rd = 1'b1;
            d.to_rs = 1'b1;
        end
        OPC_JALR: begin
            d.inst_class = CLS_JALR;
            d.imm = i_imm;
            d.writes_rd = 1'b1;
            d.rob_ready = 1'b1;
            d.rob_ans = pc + 32'd4;
        end
        OPC_BRANCH: begin
            d.inst_class = CLS_BRANCH;
            d.imm = b_imm;
            d.rd = '0;
            d.rob_type = BRANCH;
            d.to_rs = 1'b1;
        end
        OPC_LOAD: begin
            d.inst_class = CLS_LOAD;
            d.imm = i_imm;
            d.writes_rd = 1'b1;
            d.to_lsb = 1'b1;
        end
        OPC_STORE: begin
            d.inst_class = CLS_STORE;
            d.imm = s_imm;
            d.rd = '0;
            d.rob_type = STORE;
            d.rob_ready = 1'b1;
            d.to_lsb = 1'b1;
            d.is_store = 1'b1;
        end
        OPC_OP_IMM: begin
            d.inst_class = CLS_OP_IMM;
            d.imm = i_imm;
            d.writes_rd = 1'b1;
            d.to_rs = 1'b1;
        end
        OPC_OP: begin
            d.inst_class = CLS_OP;
            d.writes_rd = 1'b1;
            d.to_rs = 1'b1;
        end
        default: d.inst_class = CLS_ILLEGAL;
    endcase
    return d;
endfunction

`endif

/* testbench/tb_issue_decoder.sv */
`timescale 1ns/1ps
`include "decode_params.svh"

module tb_issue_decoder;
    import decode_pkg::*;

    `include "tb_decoder_model.svh"

    localparam int N_RANDOM = 400;
    // a waiting JALR takes the most cycles per instruction, about five
    localparam int STIM_CYCLES = 8 + N_RANDOM * 5 + 300;
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES;

    logic                          clk;
    logic                          reset;
    logic                          rollback;
    logic                          inst_valid;
    word_t                         inst;
    word_t                         inst_pc;
    logic                          pred_jump;
    logic                          inst_ready;
    reg_idx_t [`NUM_SRC-1:0]       rs_index;
    src_lookup_t [`NUM_SRC-1:0]    src_lookup;
    cdb_t                          alu_cdb;
    cdb_t                          lsb_cdb;
    rob_tag_t                      alloc_tag;
    logic                          rob_credit_return;
    logic                          lsb_credit_return;
    logic                          dispatch_valid;
    dispatch_t                     dispatch;
    logic                          redirect_valid;
    word_t                         redirect_pc;
    logic                          jalr_stall;

    // expected dispatch records and JALR targets, oldest first
    dispatch_t exp_q[$];
    word_t     target_q[$];
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    issue_decoder_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .rollback          (rollback),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .inst_pc           (inst_pc),
        .pred_jump         (pred_jump),
        .inst_ready        (inst_ready),
        .rs_index          (rs_index),
        .src_lookup        (src_lookup),
        .alu_cdb           (alu_cdb),
        .lsb_cdb           (lsb_cdb),
        .alloc_tag         (alloc_tag),
        .rob_credit_return (rob_credit_return),
        .lsb_credit_return (lsb_credit_return),
        .dispatch_valid    (dispatch_valid),
        .dispatch          (dispatch),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc),
        .jalr_stall        (jalr_stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got=%0h exp=%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic quiet_inputs();
        rollback          = 1'b0;
        inst_valid        = 1'b0;
        inst              = '0;
        inst_pc           = '0;
        pred_jump         = 1'b0;
        src_lookup        = '0;
        alu_cdb           = '0;
        lsb_cdb           = '0;
        alloc_tag         = '0;
        rob_credit_return = 1'b0;
        lsb_credit_return = 1'b0;
    endtask

    // all stimulus changes on the falling edge, one cycle per call
    task automatic next_cycle();
        @(negedge clk);
        quiet_inputs();
    endtask

    // mode 0 random operands, 1 rs1 clean, 2 rs1 in flight with no broadcast hit
    task automatic issue(input word_t word, input int mode, input logic ret_rob,
                         input logic ret_lsb, output logic waits,
                         output rob_tag_t wtag, output word_t woff);
        dispatch_t exp;
        logic [31:0] r;
        next_cycle();
        while (!inst_ready) begin
            next_cycle();
        end
        src_lookup[0] = rand_lookup();
        src_lookup[1] = rand_lookup();
        alu_cdb = rand_cdb(src_lookup[0].rob_tag, src_lookup[1].rob_tag);
        lsb_cdb = rand_cdb(src_lookup[1].rob_tag, src_lookup[0].rob_tag);
        if (mode == 1) begin
            src_lookup[0].dirty = 1'b0;
        end else if (mode == 2) begin
            src_lookup[0].dirty     = 1'b1;
            src_lookup[0].rob_ready = 1'b0;
            alu_cdb.valid           = 1'b0;
            lsb_cdb.valid           = 1'b0;
        end
        r = xorshift();
        inst_valid = 1'b1;
        inst       = word;
        inst_pc    = {r[31:2], 2'b00};
        pred_jump  = r[0];
        alloc_tag  = r[7:4];
        exp.dec = ref_decode(word, inst_pc, pred_jump);
        for (int i = 0; i < `NUM_SRC; i++) begin
            exp.src[i] = ref_operand(src_lookup[i], alu_cdb, lsb_cdb);
        end
        exp.rob_tag = alloc_tag;
        exp_q.push_back(exp);
        // a return in the acceptance cycle cancels the spend
        rob_credit_return = ret_rob;
        lsb_credit_return = ret_lsb && exp.dec.to_lsb;
        waits = 1'b0;
        wtag  = exp.src[0].rob_tag;
        woff  = exp.dec.jalr_offset;
        if (exp.dec.inst_class == CLS_JALR) begin
            if (exp.src[0].need_rob) begin
                waits = 1'b1;
            end else begin
                target_q.push_back(jalr_target(exp.src[0].value, woff));
            end
        end
        // the register file ports carry the rs1 and rs2 fields of the word
        @(posedge clk);
        check_value("rs_index0", rs_index[0], word[19:15]);
        check_value("rs_index1", rs_index[1], word[24:20]);
    endtask

    // called right after a JALR was issued whose rs1 is still in flight
    task automatic release_jalr(input rob_tag_t tag, input word_t off);
        word_t value;
        logic [31:0] r;
        next_cycle();
        check_value("jalr_stall", jalr_stall, 1);
        check_value("inst_ready", inst_ready, 0);
        // a broadcast for another entry must leave the wait alone
        alu_cdb.valid = 1'b1;
        alu_cdb.tag   = tag ^ 4'h1;
        alu_cdb.value = xorshift();
        next_cycle();
        check_value("jalr_stall", jalr_stall, 1);
        check_value("inst_ready", inst_ready, 0);
        r = xorshift();
        value = xorshift();
        if (r[0]) begin
            lsb_cdb.valid = 1'b1;
            lsb_cdb.tag   = tag;
            lsb_cdb.value = value;
        end else begin
            alu_cdb.valid = 1'b1;
            alu_cdb.tag   = tag;
            alu_cdb.value = value;
        end
        target_q.push_back(jalr_target(value, off));
        next_cycle();
        check_value("jalr_stall", jalr_stall, 0);
        check_value("inst_ready", inst_ready, 1);
    endtask

    // one return pulse per cycle on each counter
    task automatic return_credits(input int n_rob, input int n_lsb);
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            rob_credit_return = (i < n_rob);
            lsb_credit_return = (i < n_lsb);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset) begin
            if (dispatch_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("dispatch_valid rose with no instruction pending at %0t", $time);
                end else begin
                    dispatch_t e;
                    e = exp_q.pop_front();
                    check_value("dispatch.dec", dispatch.dec, e.dec);
                    check_value("dispatch.src0", dispatch.src[0], e.src[0]);
                    check_value("dispatch.src1", dispatch.src[1], e.src[1]);
                    check_value("dispatch.rob_tag", dispatch.rob_tag, e.rob_tag);
                end
            end
            if (redirect_valid) begin
                if (target_q.size() == 0) begin
                    errors++;
                    $display("redirect_valid rose with no JALR target pending at %0t", $time);
                end else begin
                    check_value("redirect_pc", redirect_pc, target_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the DUT stopped responding", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic        waits;
        rob_tag_t    wtag;
        word_t       woff;
        logic [31:0] r;
        quiet_inputs();
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("inst_ready", inst_ready, 1);
        check_value("dispatch_valid", dispatch_valid, 0);
        check_value("redirect_valid", redirect_valid, 0);
        check_value("jalr_stall", jalr_stall, 0);

        // every class with random operands, credits handed back at once
        for (int n = 0; n < N_RANDOM; n++) begin
            r = xorshift();
            issue(gen_inst(int'(r % 8)), 0, 1'b1, 1'b1, waits, wtag, woff);
            if (waits) begin
                release_jalr(wtag, woff);
            end
        end

        // JALR with rs1 known, then with rs1 waiting for a broadcast
        for (int n = 0; n < 8; n++) begin
            issue(gen_inst(2), 1, 1'b1, 1'b1, waits, wtag, woff);
        end
        for (int n = 0; n < 8; n++) begin
            issue(gen_inst(2), 2, 1'b1, 1'b1, waits, wtag, woff);
            release_jalr(wtag, woff);
        end

        // ROB credits run out after sixteen, a single return admits one more
        for (int n = 0; n < 16; n++) begin
            issue(gen_inst(6), 1, 1'b0, 1'b0, waits, wtag, woff);
        end
        next_cycle();
        check_value("inst_ready", inst_ready, 0);
        rob_credit_return = 1'b1;
        next_cycle();
        check_value("inst_ready", inst_ready, 1);
        issue(gen_inst(7), 1, 1'b0, 1'b0, waits, wtag, woff);
        next_cycle();
        check_value("inst_ready", inst_ready, 0);
        return_credits(16, 0);

        // the same for the LSB counter with loads and stores
        for (int n = 0; n < 16; n++) begin
            issue(gen_inst(4 + n % 2), 1, 1'b1, 1'b0, waits, wtag, woff);
        end
        next_cycle();
        check_value("inst_ready", inst_ready, 0);
        lsb_credit_return = 1'b1;
        next_cycle();
        check_value("inst_ready", inst_ready, 1);
        issue(gen_inst(5), 1, 1'b1, 1'b0, waits, wtag, woff);
        next_cycle();
        check_value("inst_ready", inst_ready, 0);
        return_credits(0, 16);

        // rollback in the middle of a JALR wait with credits spent
        for (int n = 0; n < 5; n++) begin
            issue(gen_inst(5), 1, 1'b0, 1'b0, waits, wtag, woff);
        end
        issue(gen_inst(2), 2, 1'b0, 1'b0, waits, wtag, woff);
        next_cycle();
        check_value("jalr_stall", jalr_stall, 1);
        rollback = 1'b1;
        next_cycle();
        check_value("jalr_stall", jalr_stall, 0);
        check_value("inst_ready", inst_ready, 1);
        // full counters again, so exactly sixteen loads fit
        for (int n = 0; n < 16; n++) begin
            issue(gen_inst(4), 1, 1'b0, 1'b0, waits, wtag, woff);
        end
        next_cycle();
        check_value("inst_ready", inst_ready, 0);
        rollback = 1'b1;
        repeat (4) next_cycle();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d accepted instructions were never dispatched", exp_q.size());
        end
        if (target_q.size() != 0) begin
            errors++;
            $display("%0d JALR redirects never arrived", target_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
